// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vram_regs
FLIST     ?= vram_regs.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/vram_regs_config.svh ====
// build-time sizes for the VRAM register block
// memory address width, number of address channels,
// nibble write mask value after reset
`ifndef VRAM_REGS_CONFIG_SVH
`define VRAM_REGS_CONFIG_SVH

`define VRAM_ADDR_W      16     // VRAM word address width
`define VRAM_NUM_CHAN    3      // RD, WR and RW channels
`define VRAM_WRMASK_RST  4'hF   // all nibbles enabled

`endif

// ==== tb/tb_vram_regs.sv ====
// testbench for the VRAM register block
// clock and reset, host bus tasks, busy and write polls,
// protocol and value assertions, per-test report
`default_nettype none

`include "vram_regs_config.svh"

module tb_vram_regs;
    timeunit 1ns;
    timeprecision 100ps;
    import vram_regs_pkg::*;

    localparam int POLL_LIMIT = 40;         // cycles before a wait gives up

    logic                    clk;
    logic                    reset_i;
    logic                    wr_strobe;
    logic                    rd_strobe;
    reg_num_e                reg_num;
    logic                    bytesel;
    byte_t                   bus_wdata;
    byte_t                   bus_rdata;
    logic                    vram_sel;
    logic                    vram_wr;
    logic [3:0]              vram_wrmask;
    logic [`VRAM_ADDR_W-1:0] vram_addr;
    word_t                   vram_wdata;
    word_t                   vram_rdata;
    logic                    vram_ack;
    int                      wr_count;
    word_t                   last_addr;
    word_t                   last_data;
    logic [3:0]              last_mask;
    logic                    chk_en;        // compare request, one cycle
    word_t                   chk_exp;
    word_t                   chk_act;
    string                   chk_name;
    string                   cur_test;
    int                      errors;
    int                      tests_run;
    int                      tests_failed;
    int                      err_at_start;

    vram_regs u_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .bus_wr_strobe_i (wr_strobe),
        .bus_rd_strobe_i (rd_strobe),
        .bus_reg_num_i   (reg_num),
        .bus_bytesel_i   (bytesel),
        .bus_data_i      (bus_wdata),
        .bus_data_o      (bus_rdata),
        .vram_sel_o      (vram_sel),
        .vram_wr_o       (vram_wr),
        .vram_wrmask_o   (vram_wrmask),
        .vram_addr_o     (vram_addr),
        .vram_data_o     (vram_wdata),
        .vram_data_i     (vram_rdata),
        .vram_ack_i      (vram_ack)
    );

    vram_model u_vram (
        .clk         (clk),
        .reset_i     (reset_i),
        .sel_i       (vram_sel),
        .wr_i        (vram_wr),
        .addr_i      (vram_addr),
        .data_i      (vram_wdata),
        .wrmask_i    (vram_wrmask),
        .data_o      (vram_rdata),
        .ack_o       (vram_ack),
        .wr_count_o  (wr_count),
        .last_addr_o (last_addr),
        .last_data_o (last_data),
        .last_mask_o (last_mask)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;             // 100 ns period
    end

    a_value: assert property (@(posedge clk) chk_en |-> (chk_act == chk_exp))
        else begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, chk_name, chk_exp, chk_act);
            errors = errors + 1;
        end

    a_reset_sel: assert property (@(posedge clk) reset_i |=> !vram_sel)
        else begin
            $display("VRAM select was high after a reset cycle");
            errors = errors + 1;
        end

    // access held until ack
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
            vram_sel && !vram_ack |=> vram_sel && $stable(vram_addr)
                                      && $stable(vram_wdata) && $stable(vram_wr)
                                      && $stable(vram_wrmask))
        else begin
            $display("VRAM access changed or dropped before its ack");
            errors = errors + 1;
        end

    a_drop: assert property (@(posedge clk) disable iff (reset_i) vram_ack |=> !vram_sel)
        else begin
            $display("VRAM select still high the cycle after the ack");
            errors = errors + 1;
        end

    // all bus tasks start and end 5 ns after a rising edge
    task automatic write_reg(input reg_num_e num, input logic bsel, input byte_t val);
        reg_num   = num;
        bytesel   = bsel;
        bus_wdata = val;
        wr_strobe = 1'b1;
        @(posedge clk);
        #5;
        wr_strobe = 1'b0;
    endtask

    task automatic read_reg(input reg_num_e num, input logic bsel, output byte_t val);
        reg_num   = num;
        bytesel   = bsel;
        rd_strobe = 1'b1;
        @(negedge clk);
        val = bus_rdata;                    // mid cycle, mux settled
        @(posedge clk);
        #5;
        rd_strobe = 1'b0;
    endtask

    task automatic write_word(input reg_num_e num, input word_t w);
        write_reg(num, 1'b0, w[15:8]);      // even byte first
        write_reg(num, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input reg_num_e num, output word_t w);
        byte_t hi;
        byte_t lo;
        read_reg(num, 1'b0, hi);
        read_reg(num, 1'b1, lo);            // odd byte may pre-read
        w = {hi, lo};
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        chk_name = name;
        chk_exp  = exp;
        chk_act  = act;
        chk_en   = 1'b1;
        @(posedge clk);
        #5;
        chk_en = 1'b0;
    endtask

    task automatic wait_idle();
        byte_t st;
        int    n;
        n = 0;
        read_reg(SYS_CTRL, 1'b0, st);
        while (st[7] && n < POLL_LIMIT) begin
            n++;
            read_reg(SYS_CTRL, 1'b0, st);
        end
        if (st[7]) begin
            $display("timeout: busy never cleared in test %s", cur_test);
            errors = errors + 1;
        end
    endtask

    task automatic wait_write(input int prev);
        int n;
        n = 0;
        while (wr_count == prev && n < POLL_LIMIT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (wr_count == prev) begin
            $display("timeout: no VRAM write arrived in test %s", cur_test);
            errors = errors + 1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != err_at_start) begin
            tests_failed++;
            $display("test %-24s FAIL", cur_test);
        end else begin
            $display("test %-24s ok", cur_test);
        end
    endtask

    task automatic check_chan_regs(input reg_num_e incr_reg, input reg_num_e addr_reg,
                                   input word_t addr, input word_t incr);
        word_t w;
        write_word(incr_reg, 16'h0000);     // read on ADDR load then leaves it put
        write_word(addr_reg, addr);
        wait_idle();
        read_word(addr_reg, w);
        check_value(addr_reg.name(), addr, w);
        write_word(incr_reg, incr);
        read_word(incr_reg, w);
        check_value(incr_reg.name(), incr, w);
    endtask

    initial begin
        word_t w;
        word_t exp_addr;
        word_t wr_words [3];
        byte_t st;
        int    cnt;
        reset_i      = 1'b1;
        wr_strobe    = 1'b0;
        rd_strobe    = 1'b0;
        reg_num      = SYS_CTRL;
        bytesel      = 1'b0;
        bus_wdata    = 8'h00;
        chk_en       = 1'b0;
        chk_exp      = 16'h0000;
        chk_act      = 16'h0000;
        chk_name     = "";
        cur_test     = "";
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_at_start = 0;
        wr_words     = '{16'hBEEF, 16'h1234, 16'hC0DE};
        repeat (10) @(posedge clk);
        #5;
        reset_i = 1'b0;

        start_test("reset state");
        read_word(SYS_CTRL, w);
        check_value("SYS_CTRL", 16'h000F, w);   // idle, no rw incr, mask F
        check_value("vram_sel_o", 16'h0000, {15'b0, vram_sel});
        finish_test();

        start_test("register readback");
        check_chan_regs(RD_INCR, RD_ADDR, 16'h4567, 16'h0102);
        check_chan_regs(WR_INCR, WR_ADDR, 16'h89AB, 16'h0304);
        check_chan_regs(RW_INCR, RW_ADDR, 16'hCDEF, 16'h0506);
        finish_test();

        start_test("write channel");
        write_reg(SYS_CTRL, 1'b1, 8'h06);       // mask 6
        write_word(WR_INCR, 16'h0010);
        write_word(WR_ADDR, 16'h1000);
        exp_addr = 16'h1000;
        for (int k = 0; k < 3; k++) begin
            cnt = wr_count;
            if (k == 1) begin
                write_word(DATA_2, wr_words[k]);
            end else begin
                write_word(DATA, wr_words[k]);
            end
            wait_write(cnt);
            check_value("write address", exp_addr, last_addr);
            check_value("write data", wr_words[k], last_data);
            check_value("write mask", 16'h0006, {12'b0, last_mask});
            wait_idle();
            exp_addr = exp_addr + 16'h0010;
        end
        read_word(WR_ADDR, w);
        check_value("WR_ADDR after writes", exp_addr, w);
        finish_test();

        start_test("read pre-read");
        write_word(RD_INCR, 16'h0001);
        write_word(RD_ADDR, 16'h2345);
        wait_idle();
        read_word(DATA, w);
        check_value("first DATA word", 16'h2345 ^ 16'hA5A5, w);
        wait_idle();
        read_word(DATA, w);
        check_value("pre-read DATA word", 16'h2346 ^ 16'hA5A5, w);
        wait_idle();
        finish_test();

        start_test("rw channel");
        write_word(RW_INCR, 16'h0003);
        write_word(RW_ADDR, 16'h3000);
        wait_idle();
        read_word(RW_DATA, w);
        check_value("RW_DATA first read", 16'h3000 ^ 16'hA5A5, w);
        wait_idle();
        read_word(RW_DATA, w);
        check_value("RW_DATA repeat read", 16'h3000 ^ 16'hA5A5, w);
        wait_idle();
        read_word(RW_ADDR, w);
        check_value("RW_ADDR after reads", 16'h3000, w);
        cnt = wr_count;
        write_word(RW_DATA, 16'h5A5A);
        wait_write(cnt);
        check_value("RW write address", 16'h3000, last_addr);
        wait_idle();
        read_word(RW_ADDR, w);
        check_value("RW_ADDR after write", 16'h3003, w);
        write_reg(SYS_CTRL, 1'b0, 8'h01);       // rw reads now advance
        read_word(RW_DATA_2, w);
        wait_idle();
        read_word(RW_ADDR, w);
        check_value("RW_ADDR after read", 16'h3006, w);
        read_word(RW_DATA, w);
        check_value("RW_DATA advanced read", 16'h3003 ^ 16'hA5A5, w);
        wait_idle();
        finish_test();

        start_test("busy flag");
        write_word(RD_ADDR, 16'h0400);
        read_reg(SYS_CTRL, 1'b0, st);           // before any ack can come
        check_value("busy during access", 16'h0001, {15'b0, st[7]});
        wait_idle();
        read_reg(SYS_CTRL, 1'b0, st);
        check_value("busy after ack", 16'h0000, {15'b0, st[7]});
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/vram_model.sv ====
// behavioral VRAM for the testbench
// address based fill, nibble masked writes, LFSR driven ack delay,
// last write address, data and mask for checking
`default_nettype none

module vram_model (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        sel_i,
    input  wire logic        wr_i,
    input  wire logic [15:0] addr_i,
    input  wire logic [15:0] data_i,
    input  wire logic [3:0]  wrmask_i,
    output      logic [15:0] data_o,        // valid with ack
    output      logic        ack_o,
    output      int          wr_count_o,    // completed writes
    output      logic [15:0] last_addr_o,
    output      logic [15:0] last_data_o,
    output      logic [3:0]  last_mask_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [0:65535];
    logic [15:0] lfsr;                      // delay source
    logic [15:0] step;
    logic [15:0] merged;                    // word after masked write
    logic [1:0]  delay_bits;
    logic [1:0]  delay_cnt;
    logic        pending;                   // access seen, ack not yet given

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 16'(i) ^ 16'hA5A5;     // unwritten words read addr ^ A5A5
        end
    end

    always @(posedge clk) begin
        ack_o <= 1'b0;
        if (reset_i) begin
            pending    <= 1'b0;
            wr_count_o <= 0;
            lfsr       <= 16'd60;           // seed
        end else if (pending) begin
            if (delay_cnt == 2'd0) begin
                ack_o   <= 1'b1;
                pending <= 1'b0;
                data_o  <= mem[addr_i];     // old word, read before the write
                if (wr_i) begin
                    merged = mem[addr_i];
                    for (int n = 0; n < 4; n++) begin
                        if (wrmask_i[n]) begin
                            merged[n*4 +: 4] = data_i[n*4 +: 4];
                        end
                    end
                    mem[addr_i] = merged;
                    last_addr_o <= addr_i;
                    last_data_o <= data_i;
                    last_mask_o <= wrmask_i;
                    wr_count_o  <= wr_count_o + 1;
                end
            end else begin
                delay_cnt <= delay_cnt - 2'd1;
            end
        end else if (sel_i && !ack_o) begin
            step          = lfsr;
            delay_bits[0] = step[0];        // one step per bit taken
            step          = lfsr_next(step);
            delay_bits[1] = step[0];
            step          = lfsr_next(step);
            lfsr      <= step;
            delay_cnt <= delay_bits;        // ack 1 to 4 cycles later
            pending   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/addr_channel.sv ====
// one VRAM address channel
// address and increment registers loaded by byte,
// post-increment of the address on advance
`default_nettype none

`include "vram_regs_config.svh"

module addr_channel (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    addr_ld_hi_i,   // even byte of ADDR
    input  wire logic                    addr_ld_lo_i,   // odd byte of ADDR
    input  wire logic                    incr_ld_hi_i,
    input  wire logic                    incr_ld_lo_i,
    input  wire logic [7:0]              ld_byte_i,
    input  wire logic                    adv_i,          // access done, step address
    output      logic [`VRAM_ADDR_W-1:0] addr_o,
    output      logic [15:0]             incr_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_o <= '0;
            incr_o <= '0;
        end else begin
            if (incr_ld_hi_i) begin
                incr_o[15:8] <= ld_byte_i;
            end
            if (incr_ld_lo_i) begin
                incr_o[7:0] <= ld_byte_i;
            end
            // host load wins over advance
            if (addr_ld_hi_i) begin
                addr_o[`VRAM_ADDR_W-1:8] <= ld_byte_i[`VRAM_ADDR_W-9:0];
            end else if (addr_ld_lo_i) begin
                addr_o[7:0] <= ld_byte_i;
            end else if (adv_i) begin
                addr_o <= addr_o + incr_o[`VRAM_ADDR_W-1:0];    // wraps at width
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bus_reg_port.sv ====
// host register port
// byte write decode into channel loads, even byte latches,
// SYS_CTRL bits, registered access requests, read back mux
`default_nettype none

`include "vram_regs_config.svh"

module bus_reg_port (
    input  wire logic                              clk,
    input  wire logic                              reset_i,
    input  wire logic                              bus_wr_strobe_i,  // 1-cycle byte write
    input  wire logic                              bus_rd_strobe_i,  // 1-cycle byte read
    input  wire vram_regs_pkg::reg_num_e           bus_reg_num_i,
    input  wire logic                              bus_bytesel_i,    // 0 = even (high) byte
    input  wire vram_regs_pkg::byte_t              bus_data_i,
    output      vram_regs_pkg::byte_t              bus_data_o,
    output      logic [`VRAM_NUM_CHAN-1:0]         addr_ld_hi_o,
    output      logic [`VRAM_NUM_CHAN-1:0]         addr_ld_lo_o,
    output      logic [`VRAM_NUM_CHAN-1:0]         incr_ld_hi_o,
    output      logic [`VRAM_NUM_CHAN-1:0]         incr_ld_lo_o,
    output      vram_regs_pkg::byte_t              ld_byte_o,        // byte for all loads
    input  wire logic [`VRAM_NUM_CHAN-1:0][`VRAM_ADDR_W-1:0] chan_addr_i,
    input  wire vram_regs_pkg::word_t [`VRAM_NUM_CHAN-1:0]   chan_incr_i,
    input  wire vram_regs_pkg::word_t              rd_data_i,        // DATA read word
    input  wire vram_regs_pkg::word_t              rw_data_i,        // RW_DATA read word
    input  wire logic                              busy_i,
    output      logic                              req_o,
    output      vram_access_pkg::access_op_e       req_op_o,
    output      vram_access_pkg::chan_e            req_chan_o,
    output      vram_regs_pkg::word_t              req_wdata_o,
    output      logic                              rw_rd_inc_o,
    output      logic [3:0]                        wrmask_o
);
    import vram_regs_pkg::*;
    import vram_access_pkg::*;

    byte_t data_even;               // DATA even byte
    byte_t rw_data_even;            // RW_DATA even byte
    word_t rd_word;                 // addressed register for host read

    assign ld_byte_o = bus_data_i;

    // channel byte loads, taken by the channel on the next edge
    always_comb begin
        addr_ld_hi_o = '0;
        addr_ld_lo_o = '0;
        incr_ld_hi_o = '0;
        incr_ld_lo_o = '0;
        if (bus_wr_strobe_i) begin
            case (bus_reg_num_i)
                RD_INCR: begin
                    incr_ld_hi_o[CH_RD] = !bus_bytesel_i;
                    incr_ld_lo_o[CH_RD] = bus_bytesel_i;
                end
                RD_ADDR: begin
                    addr_ld_hi_o[CH_RD] = !bus_bytesel_i;
                    addr_ld_lo_o[CH_RD] = bus_bytesel_i;
                end
                WR_INCR: begin
                    incr_ld_hi_o[CH_WR] = !bus_bytesel_i;
                    incr_ld_lo_o[CH_WR] = bus_bytesel_i;
                end
                WR_ADDR: begin
                    addr_ld_hi_o[CH_WR] = !bus_bytesel_i;
                    addr_ld_lo_o[CH_WR] = bus_bytesel_i;
                end
                RW_INCR: begin
                    incr_ld_hi_o[CH_RW] = !bus_bytesel_i;
                    incr_ld_lo_o[CH_RW] = bus_bytesel_i;
                end
                RW_ADDR: begin
                    addr_ld_hi_o[CH_RW] = !bus_bytesel_i;
                    addr_ld_lo_o[CH_RW] = bus_bytesel_i;
                end
                default: ;
            endcase
        end
    end

    // SYS_CTRL bits and request strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_o       <= 1'b0;
            req_op_o    <= OP_NONE;
            req_chan_o  <= CH_RD;
            rw_rd_inc_o <= 1'b0;
            wrmask_o    <= `VRAM_WRMASK_RST;
        end else begin
            req_o    <= 1'b0;                       // single cycle pulse
            req_op_o <= OP_NONE;
            if (bus_wr_strobe_i) begin
                case (bus_reg_num_i)
                    SYS_CTRL: begin
                        if (!bus_bytesel_i) begin
                            rw_rd_inc_o <= bus_data_i[0];
                        end else begin
                            wrmask_o    <= bus_data_i[3:0];
                        end
                    end
                    RD_ADDR, RW_ADDR: begin
                        if (bus_bytesel_i) begin    // address complete, read it
                            req_o      <= 1'b1;
                            req_op_o   <= OP_READ;
                            req_chan_o <= (bus_reg_num_i == RD_ADDR) ? CH_RD : CH_RW;
                        end
                    end
                    DATA, DATA_2, RW_DATA, RW_DATA_2: begin
                        if (bus_bytesel_i) begin    // word complete, write it
                            req_o      <= 1'b1;
                            req_op_o   <= OP_WRITE;
                            req_chan_o <= (bus_reg_num_i inside {DATA, DATA_2}) ? CH_WR : CH_RW;
                        end
                    end
                    default: ;
                endcase
            end
            // odd byte read of a data port pre-reads the next word
            if (bus_rd_strobe_i && bus_bytesel_i) begin
                if (bus_reg_num_i inside {DATA, DATA_2}) begin
                    req_o      <= 1'b1;
                    req_op_o   <= OP_READ;
                    req_chan_o <= CH_RD;
                end
                if (bus_reg_num_i inside {RW_DATA, RW_DATA_2}) begin
                    req_o      <= 1'b1;
                    req_op_o   <= OP_READ;
                    req_chan_o <= CH_RW;
                end
            end
        end
    end

    // even byte latches and write word
    always_ff @(posedge clk) begin
        if (bus_wr_strobe_i) begin
            if (bus_reg_num_i inside {DATA, DATA_2}) begin
                if (!bus_bytesel_i) begin
                    data_even <= bus_data_i;
                end
                req_wdata_o <= {data_even, bus_data_i};
            end
            if (bus_reg_num_i inside {RW_DATA, RW_DATA_2}) begin
                if (!bus_bytesel_i) begin
                    rw_data_even <= bus_data_i;
                end
                req_wdata_o <= {rw_data_even, bus_data_i};
            end
        end
    end

    always_comb begin
        case (bus_reg_num_i)
            SYS_CTRL:           rd_word = {busy_i | req_o, 6'b0, rw_rd_inc_o, 4'b0, wrmask_o};
            RD_INCR:            rd_word = chan_incr_i[CH_RD];
            RD_ADDR:            rd_word = word_t'(chan_addr_i[CH_RD]);
            WR_INCR:            rd_word = chan_incr_i[CH_WR];
            WR_ADDR:            rd_word = word_t'(chan_addr_i[CH_WR]);
            DATA, DATA_2:       rd_word = rd_data_i;
            RW_INCR:            rd_word = chan_incr_i[CH_RW];
            RW_ADDR:            rd_word = word_t'(chan_addr_i[CH_RW]);
            RW_DATA, RW_DATA_2: rd_word = rw_data_i;
            default:            rd_word = '0;       // unused numbers
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

endmodule

`default_nettype wire

// ==== verilog/vram_access_ctrl.sv ====
// VRAM access controller
// one access at a time, channel address select,
// read data capture and channel advance on ack
`default_nettype none

`include "vram_regs_config.svh"

module vram_access_ctrl (
    input  wire logic                              clk,
    input  wire logic                              reset_i,
    input  wire logic                              req_i,
    input  wire vram_access_pkg::access_op_e       req_op_i,
    input  wire vram_access_pkg::chan_e            req_chan_i,
    input  wire vram_regs_pkg::word_t              req_wdata_i,
    input  wire logic                              rw_rd_inc_i,      // rw reads advance
    input  wire logic [3:0]                        wrmask_i,
    input  wire logic [`VRAM_NUM_CHAN-1:0][`VRAM_ADDR_W-1:0] chan_addr_i,
    output      logic                              vram_sel_o,
    output      logic                              vram_wr_o,
    output      logic [3:0]                        vram_wrmask_o,
    output      logic [`VRAM_ADDR_W-1:0]           vram_addr_o,
    output      vram_regs_pkg::word_t              vram_data_o,
    input  wire vram_regs_pkg::word_t              vram_data_i,      // valid with ack
    input  wire logic                              vram_ack_i,
    output      logic [`VRAM_NUM_CHAN-1:0]         chan_adv_o,
    output      vram_regs_pkg::word_t              rd_data_o,
    output      vram_regs_pkg::word_t              rw_data_o,
    output      logic                              busy_o
);
    import vram_regs_pkg::*;
    import vram_access_pkg::*;

    access_op_e cur_op;             // access in flight, OP_NONE when idle
    chan_e      cur_chan;           // channel that owns it
    logic       done;               // ack of the current access
    logic       start;              // accepted request

    assign done  = vram_sel_o && vram_ack_i;
    assign start = req_i && (req_op_i != OP_NONE) && !vram_sel_o;  // ignored while busy

    // select and direction follow the held operation
    assign vram_sel_o = (cur_op != OP_NONE);
    assign vram_wr_o  = (cur_op == OP_WRITE);
    assign busy_o     = vram_sel_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cur_op   <= OP_NONE;
            cur_chan <= CH_RD;
        end else if (done) begin
            cur_op   <= OP_NONE;                    // select drops next cycle
        end else if (start) begin
            cur_chan <= req_chan_i;
            if (req_op_i == OP_READ && req_chan_i == CH_RW) begin
                cur_op <= OP_READ_RW;               // goes to RW_DATA word
            end else begin
                cur_op <= req_op_i;
            end
        end
    end

    // address, data and mask held for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            vram_addr_o   <= chan_addr_i[req_chan_i];
            vram_data_o   <= req_wdata_i;
            vram_wrmask_o <= wrmask_i;
        end
    end

    // read capture on ack
    always_ff @(posedge clk) begin
        if (done && cur_op == OP_READ) begin
            rd_data_o <= vram_data_i;
        end
        if (done && cur_op == OP_READ_RW) begin
            rw_data_o <= vram_data_i;
        end
    end

    // post-increment, rw reads only when enabled
    always_comb begin
        chan_adv_o = '0;
        if (done && (cur_op != OP_READ_RW || rw_rd_inc_i)) begin
            chan_adv_o[cur_chan] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vram_access_pkg.sv ====
// memory side definitions
// channel index and access operation encodings
`default_nettype none

package vram_access_pkg;

    typedef enum logic [1:0] {
        CH_RD = 2'd0,               // read channel
        CH_WR = 2'd1,               // write channel
        CH_RW = 2'd2                // read/write channel
    } chan_e;

    typedef enum logic [1:0] {
        OP_NONE    = 2'd0,          // idle / no request
        OP_READ    = 2'd1,
        OP_WRITE   = 2'd2,
        OP_READ_RW = 2'd3           // controller only, load rw capture
    } access_op_e;

endpackage

`default_nettype wire

// ==== verilog/vram_regs.sv ====
// VRAM register block top level
// host register port, address channels, access controller
`default_nettype none

`include "vram_regs_config.svh"

module vram_regs (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        bus_wr_strobe_i,
    input  wire logic                        bus_rd_strobe_i,
    input  wire vram_regs_pkg::reg_num_e     bus_reg_num_i,
    input  wire logic                        bus_bytesel_i,
    input  wire vram_regs_pkg::byte_t        bus_data_i,
    output      vram_regs_pkg::byte_t        bus_data_o,
    output      logic                        vram_sel_o,
    output      logic                        vram_wr_o,
    output      logic [3:0]                  vram_wrmask_o,
    output      logic [`VRAM_ADDR_W-1:0]     vram_addr_o,
    output      vram_regs_pkg::word_t        vram_data_o,
    input  wire vram_regs_pkg::word_t        vram_data_i,
    input  wire logic                        vram_ack_i
);
    import vram_regs_pkg::*;
    import vram_access_pkg::*;

    logic [`VRAM_NUM_CHAN-1:0]                   addr_ld_hi;
    logic [`VRAM_NUM_CHAN-1:0]                   addr_ld_lo;
    logic [`VRAM_NUM_CHAN-1:0]                   incr_ld_hi;
    logic [`VRAM_NUM_CHAN-1:0]                   incr_ld_lo;
    byte_t                                       ld_byte;
    logic [`VRAM_NUM_CHAN-1:0]                   chan_adv;
    logic [`VRAM_NUM_CHAN-1:0][`VRAM_ADDR_W-1:0] chan_addr;
    word_t [`VRAM_NUM_CHAN-1:0]                  chan_incr;
    word_t                                       rd_data;    // DATA word
    word_t                                       rw_data;    // RW_DATA word
    logic                                        busy;
    logic                                        req;
    access_op_e                                  req_op;
    chan_e                                       req_chan;
    word_t                                       req_wdata;
    logic                                        rw_rd_inc;
    logic [3:0]                                  wrmask;

    bus_reg_port u_port (
        .clk             (clk),
        .reset_i         (reset_i),
        .bus_wr_strobe_i (bus_wr_strobe_i),
        .bus_rd_strobe_i (bus_rd_strobe_i),
        .bus_reg_num_i   (bus_reg_num_i),
        .bus_bytesel_i   (bus_bytesel_i),
        .bus_data_i      (bus_data_i),
        .bus_data_o      (bus_data_o),
        .addr_ld_hi_o    (addr_ld_hi),
        .addr_ld_lo_o    (addr_ld_lo),
        .incr_ld_hi_o    (incr_ld_hi),
        .incr_ld_lo_o    (incr_ld_lo),
        .ld_byte_o       (ld_byte),
        .chan_addr_i     (chan_addr),
        .chan_incr_i     (chan_incr),
        .rd_data_i       (rd_data),
        .rw_data_i       (rw_data),
        .busy_i          (busy),
        .req_o           (req),
        .req_op_o        (req_op),
        .req_chan_o      (req_chan),
        .req_wdata_o     (req_wdata),
        .rw_rd_inc_o     (rw_rd_inc),
        .wrmask_o        (wrmask)
    );

    // RD, WR and RW channels, indexed by chan_e
    for (genvar i = 0; i < `VRAM_NUM_CHAN; i++) begin : g_chan
        addr_channel u_chan (
            .clk          (clk),
            .reset_i      (reset_i),
            .addr_ld_hi_i (addr_ld_hi[i]),
            .addr_ld_lo_i (addr_ld_lo[i]),
            .incr_ld_hi_i (incr_ld_hi[i]),
            .incr_ld_lo_i (incr_ld_lo[i]),
            .ld_byte_i    (ld_byte),
            .adv_i        (chan_adv[i]),
            .addr_o       (chan_addr[i]),
            .incr_o       (chan_incr[i])
        );
    end

    vram_access_ctrl u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_i         (req),
        .req_op_i      (req_op),
        .req_chan_i    (req_chan),
        .req_wdata_i   (req_wdata),
        .rw_rd_inc_i   (rw_rd_inc),
        .wrmask_i      (wrmask),
        .chan_addr_i   (chan_addr),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_wrmask_o (vram_wrmask_o),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o),
        .vram_data_i   (vram_data_i),
        .vram_ack_i    (vram_ack_i),
        .chan_adv_o    (chan_adv),
        .rd_data_o     (rd_data),
        .rw_data_o     (rw_data),
        .busy_o        (busy)
    );

endmodule

`default_nettype wire

// ==== verilog/vram_regs_pkg.sv ====
// host side register definitions
// word and byte types, register number map
`default_nettype none

package vram_regs_pkg;

    typedef logic [15:0] word_t;    // register / VRAM word
    typedef logic [7:0]  byte_t;    // host bus byte

    // host register numbers, 1..5 unused and read as zero
    typedef enum logic [3:0] {
        SYS_CTRL  = 4'd0,           // busy, rw read incr, write mask
        RD_INCR   = 4'd6,
        RD_ADDR   = 4'd7,           // odd byte starts a read
        WR_INCR   = 4'd8,
        WR_ADDR   = 4'd9,
        DATA      = 4'd10,          // odd byte write / read pre-read
        DATA_2    = 4'd11,          // alias of DATA
        RW_INCR   = 4'd12,
        RW_ADDR   = 4'd13,          // odd byte starts an rw read
        RW_DATA   = 4'd14,
        RW_DATA_2 = 4'd15           // alias of RW_DATA
    } reg_num_e;

endpackage

`default_nettype wire

// ==== vram_regs.f ====
+incdir+include
verilog/vram_regs_pkg.sv
verilog/vram_access_pkg.sv
verilog/addr_channel.sv
verilog/bus_reg_port.sv
verilog/vram_access_ctrl.sv
verilog/vram_regs.sv
tb/vram_model.sv
tb/tb_vram_regs.sv
